//--- soc_pkg.sv
// ================================================
// SoC bus package: request and response structs,
// decoded targets, address map and sizes
// ================================================
`default_nettype none

package soc_pkg;

  // Bus widths
  localparam int DATA_W = 16;
  localparam int ADR_W  = 19;                     // Word address, byte bit dropped

  // Memory window, words 0x00000 to 0x001FF
  localparam logic [ADR_W-1:0] RAM_BASE  = 19'h00000;
  localparam logic [ADR_W-1:0] RAM_MASK  = 19'h7FE00;

  // I/O window, bytes 0xF100 to 0xF103
  localparam logic [ADR_W-1:0] GPIO_BASE = 19'h07880;
  localparam logic [ADR_W-1:0] GPIO_MASK = 19'h7FFFE;

  localparam int RAM_WORDS = 512;
  localparam int RAM_AW    = 9;

  localparam int LED_W = 10;
  localparam int SW_W  = 10;

  // Interrupt controller
  localparam int IRQ_N = 8;
  localparam int IID_W = 3;

  localparam logic [DATA_W-1:0] VEC_BASE      = 16'h0008;  // OR-ed with iid
  localparam logic [DATA_W-1:0] DEFAULT_RDATA = 16'hFFFF;  // Unmapped reads

  typedef enum logic [1:0] {
    TGT_RAM,
    TGT_GPIO,
    TGT_IRQ_ACK,
    TGT_DEFAULT
  } bus_target_e;

  // Master to slave
  typedef struct packed {
    logic              stb;
    logic              we;
    logic              io;     // I/O cycle (tga)
    logic              inta;   // Interrupt acknowledge
    logic [ADR_W-1:0]  adr;
    logic [1:0]        sel;    // Byte lanes
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  // Slave to master
  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

//--- bus_decoder.sv
// ================================================
// Bus decoder: routes memory, I/O and acknowledge
// cycles, with a default responder for the rest
// ================================================
`default_nettype none

module bus_decoder import soc_pkg::*; (
  input  logic             clk,
  input  logic             rst_lck,
  input  bus_req_t         mst_req_i,
  output bus_rsp_t         mst_rsp_o,
  output bus_req_t         ram_req_o,
  input  bus_rsp_t         ram_rsp_i,
  output bus_req_t         gpio_req_o,
  input  bus_rsp_t         gpio_rsp_i,
  input  logic [IID_W-1:0] iid_i,
  output logic             inta_ack_o
);

  bus_target_e       tgt;
  logic              ram_hit;
  logic              gpio_hit;
  logic              stb_g;
  logic              def_ack_q;
  logic              iack_q;
  bus_rsp_t          sel_rsp;
  logic              rsp_ack_q;
  logic [DATA_W-1:0] rsp_rdata_q;
  logic              inta_ack_q;

  // Window match on the word address
  assign ram_hit  = ~mst_req_i.io & ((mst_req_i.adr & RAM_MASK) == RAM_BASE);
  assign gpio_hit = mst_req_i.io & ((mst_req_i.adr & GPIO_MASK) == GPIO_BASE);

  always_comb begin
    if (mst_req_i.inta) begin
      tgt = TGT_IRQ_ACK;
    end else if (ram_hit) begin
      tgt = TGT_RAM;
    end else if (gpio_hit) begin
      tgt = TGT_GPIO;
    end else begin
      tgt = TGT_DEFAULT;
    end
  end

  // Strobe is held off while the master sees its ack
  assign stb_g = mst_req_i.stb & ~rsp_ack_q;

  always_comb begin
    ram_req_o      = mst_req_i;
    ram_req_o.stb  = stb_g & (tgt == TGT_RAM);
    gpio_req_o     = mst_req_i;
    gpio_req_o.stb = stb_g & (tgt == TGT_GPIO);
  end

  // Default and acknowledge responders, same timing as a slave
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      def_ack_q <= 1'b0;
      iack_q    <= 1'b0;
    end else begin
      def_ack_q <= stb_g & (tgt == TGT_DEFAULT) & ~def_ack_q;
      iack_q    <= stb_g & (tgt == TGT_IRQ_ACK) & ~iack_q;
    end
  end

  always_comb begin
    case (tgt)
      TGT_RAM:     sel_rsp = ram_rsp_i;
      TGT_GPIO:    sel_rsp = gpio_rsp_i;
      TGT_IRQ_ACK: sel_rsp = '{ack: iack_q, rdata: VEC_BASE | DATA_W'(iid_i)};
      default:     sel_rsp = '{ack: def_ack_q, rdata: DEFAULT_RDATA};
    endcase
  end

  // Registered response stage
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      rsp_ack_q  <= 1'b0;
      inta_ack_q <= 1'b0;
    end else begin
      rsp_ack_q  <= sel_rsp.ack;
      inta_ack_q <= iack_q;             // Lines up with the master's ack
    end
  end

  always_ff @(posedge clk) begin
    if (sel_rsp.ack) rsp_rdata_q <= sel_rsp.rdata;
  end

  assign mst_rsp_o  = '{ack: rsp_ack_q, rdata: rsp_rdata_q};
  assign inta_ack_o = inta_ack_q;

endmodule

`default_nettype wire

//--- base_ram.sv
// ================================================
// Base RAM window, word wide with byte-lane writes
// ================================================
`default_nettype none

module base_ram import soc_pkg::*; (
  input  logic     clk,
  input  logic     rst_lck,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o
);

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [RAM_AW-1:0] idx;
  logic              access;
  logic              ack_q;
  logic [DATA_W-1:0] rdata_q;

  assign idx    = req_i.adr[RAM_AW-1:0];
  assign access = req_i.stb & ~ack_q;   // One access per strobe

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Array and read data
  always_ff @(posedge clk) begin
    if (access) begin
      if (req_i.we) begin
        if (req_i.sel[0]) mem[idx][7:0]  <= req_i.wdata[7:0];
        if (req_i.sel[1]) mem[idx][15:8] <= req_i.wdata[15:8];
      end
      rdata_q <= mem[idx];
    end
  end

  assign rsp_o = '{ack: ack_q, rdata: rdata_q};

endmodule

`default_nettype wire

//--- gpio_port.sv
// ================================================
// Switch input and LED output port, two I/O words
// ================================================
`default_nettype none

module gpio_port import soc_pkg::*; (
  input  logic             clk,
  input  logic             rst_lck,
  input  bus_req_t         req_i,
  output bus_rsp_t         rsp_o,
  input  logic [SW_W-1:0]  sw_i,
  output logic [LED_W-1:0] ledr_o
);

  logic              access;
  logic              ack_q;
  logic [LED_W-1:0]  led_q;
  logic [DATA_W-1:0] rdata_q;

  assign access = req_i.stb & ~ack_q;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      ack_q <= 1'b0;
      led_q <= '0;
    end else begin
      ack_q <= access;
      // Word 0 is the LED register, lanes written separately
      if (access && req_i.we && !req_i.adr[0]) begin
        if (req_i.sel[0]) led_q[7:0]       <= req_i.wdata[7:0];
        if (req_i.sel[1]) led_q[LED_W-1:8] <= req_i.wdata[LED_W-1:8];
      end
    end
  end

  // Word 0 switches, word 1 LED readback
  always_ff @(posedge clk) begin
    if (access) begin
      rdata_q <= req_i.adr[0] ? DATA_W'(led_q) : DATA_W'(sw_i);
    end
  end

  assign rsp_o  = '{ack: ack_q, rdata: rdata_q};
  assign ledr_o = led_q;

endmodule

`default_nettype wire

//--- irq_ctrl.sv
// ================================================
// Simple interrupt controller: latches rising edges
// and reports the lowest pending line
// ================================================
`default_nettype none

module irq_ctrl import soc_pkg::*; (
  input  logic             clk,
  input  logic             rst_lck,
  input  logic [IRQ_N-1:0] irq_i,
  input  logic             inta_ack_i,
  output logic             intr_o,
  output logic [IID_W-1:0] iid_o
);

  logic [IRQ_N-1:0] irq_q;
  logic [IRQ_N-1:0] irq_d;
  logic [IRQ_N-1:0] rise;
  logic [IRQ_N-1:0] clr;
  logic [IRQ_N-1:0] pending_q;
  logic [IID_W-1:0] iid;

  // Sample the lines, then compare with the previous sample
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      irq_q <= '0;
      irq_d <= '0;
    end else begin
      irq_q <= irq_i;
      irq_d <= irq_q;
    end
  end

  assign rise = irq_q & ~irq_d;

  // Priority pick, line 0 wins
  always_comb begin
    iid = '0;
    for (int i = IRQ_N - 1; i >= 0; i--) begin
      if (pending_q[i]) iid = IID_W'(i);
    end
  end

  assign clr = inta_ack_i ? (IRQ_N'(1) << iid) : '0;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clr) | rise;   // New edge beats the clear
    end
  end

  assign intr_o = |pending_q;
  assign iid_o  = iid;

endmodule

`default_nettype wire

//--- soc_top.sv
// ================================================
// SoC top: decoder, base RAM, GPIO and interrupt
// controller on one bus master port
// ================================================
`default_nettype none

module soc_top import soc_pkg::*; (
  input  logic             clk,
  input  logic             rst_lck,
  input  bus_req_t         bus_i,
  output bus_rsp_t         bus_o,
  input  logic [IRQ_N-1:0] irq_i,
  output logic             intr_o,
  input  logic [SW_W-1:0]  sw_i,
  output logic [LED_W-1:0] ledr_o
);

  bus_req_t         ram_req;
  bus_rsp_t         ram_rsp;
  bus_req_t         gpio_req;
  bus_rsp_t         gpio_rsp;
  logic [IID_W-1:0] iid;
  logic             inta_ack;

  bus_decoder u_dec (
    .clk        (clk),
    .rst_lck    (rst_lck),
    .mst_req_i  (bus_i),
    .mst_rsp_o  (bus_o),
    .ram_req_o  (ram_req),
    .ram_rsp_i  (ram_rsp),
    .gpio_req_o (gpio_req),
    .gpio_rsp_i (gpio_rsp),
    .iid_i      (iid),
    .inta_ack_o (inta_ack)
  );

  base_ram u_ram (
    .clk     (clk),
    .rst_lck (rst_lck),
    .req_i   (ram_req),
    .rsp_o   (ram_rsp)
  );

  gpio_port u_gpio (
    .clk     (clk),
    .rst_lck (rst_lck),
    .req_i   (gpio_req),
    .rsp_o   (gpio_rsp),
    .sw_i    (sw_i),
    .ledr_o  (ledr_o)
  );

  irq_ctrl u_pic (
    .clk        (clk),
    .rst_lck    (rst_lck),
    .irq_i      (irq_i),
    .inta_ack_i (inta_ack),
    .intr_o     (intr_o),
    .iid_o      (iid)
  );

endmodule

`default_nettype wire

//--- soc_checker.sv
// ================================================
// Bus monitor and scoreboard for the SoC testbench
// ================================================
`default_nettype none

module soc_checker import soc_pkg::*; (
  input logic             clk,
  input bus_req_t         bus_i,
  input bus_rsp_t         bus_o,
  input logic [LED_W-1:0] ledr_o,
  input logic             intr_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [DATA_W-1:0] exp_q [$];      // Expected read data, in bus order
  int                stb_edges = 0;
  int                test_errs = 0;
  int                err_total = 0;
  int                tests_run = 0;
  int                tests_failed = 0;

  task automatic report_error(input string msg);
    $display("Error: %s", msg);
    test_errs++;
    err_total++;
  endtask

  task automatic compare_value(input string name, input logic [15:0] exp, input logic [15:0] got);
    if (exp !== got) begin
      $display("CHECK FAILED %s exp=%h got=%h", name, exp, got);
      test_errs++;
      err_total++;
    end
  endtask

  task automatic expect_read(input logic [DATA_W-1:0] exp);
    exp_q.push_back(exp);
  endtask

  task automatic check_led(input logic [LED_W-1:0] exp);
    compare_value("ledr_o", 16'(exp), 16'(ledr_o));
  endtask

  task automatic check_intr(input logic exp);
    compare_value("intr_o", 16'(exp), 16'(intr_o));
  endtask

  task automatic check_ack_low();
    compare_value("bus_o.ack", 16'h0000, 16'(bus_o.ack));
  endtask

  // Watch every cycle at the top ports
  always @(posedge clk) begin : bus_monitor
    if (bus_o.ack === 1'b1) begin
      if (bus_i.stb !== 1'b1) report_error("ack was raised without a strobe");
      if (stb_edges != 2) begin
        report_error($sformatf("ack came %0d edges after the strobe instead of 2", stb_edges));
      end
      stb_edges = 0;
      if (bus_i.we !== 1'b1) begin
        if (exp_q.size() == 0) begin
          report_error("read was acked with no expected value queued");
        end else begin
          compare_value("bus_o.rdata", exp_q.pop_front(), bus_o.rdata);
        end
      end
    end else if (bus_i.stb === 1'b1) begin
      stb_edges++;                    // Edges before the ack
    end
  end

  task automatic end_test(input string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, test_errs);
      tests_failed++;
    end
    test_errs = 0;
  endtask

  task automatic print_summary();
    if (exp_q.size() != 0) report_error("expected reads were never acked");
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_total);
  endtask

endmodule

`default_nettype wire

//--- tb_soc.sv
// ================================================
// SoC testbench: bus master, interrupt stimulus and
// reference model for the bus fabric
// ================================================
`default_nettype none

module tb_soc import soc_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  logic             clk;
  logic             rst_lck;
  bus_req_t         bus_i;
  bus_rsp_t         bus_o;
  logic [IRQ_N-1:0] irq_i;
  logic             intr_o;
  logic [SW_W-1:0]  sw_i;
  logic [LED_W-1:0] ledr_o;

  logic [DATA_W-1:0] ram_model [RAM_WORDS];
  logic [LED_W-1:0]  led_model;
  logic [IRQ_N-1:0]  pend_model;
  logic [ADR_W-1:0]  test_adr [$];
  int unsigned       seed;

  soc_top dut0 (
    .clk     (clk),
    .rst_lck (rst_lck),
    .bus_i   (bus_i),
    .bus_o   (bus_o),
    .irq_i   (irq_i),
    .intr_o  (intr_o),
    .sw_i    (sw_i),
    .ledr_o  (ledr_o)
  );

  soc_checker chk0 (
    .clk    (clk),
    .bus_i  (bus_i),
    .bus_o  (bus_o),
    .ledr_o (ledr_o),
    .intr_o (intr_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] wdata,
                                               input logic [1:0] sel);
    logic [15:0] res;
    res = old;
    if (sel[0]) res[7:0] = wdata[7:0];
    if (sel[1]) res[15:8] = wdata[15:8];
    return res;
  endfunction

  // 0 RAM, 1 switch word, 2 LED word, 3 unmapped
  function automatic int region(input logic io, input logic [ADR_W-1:0] adr);
    logic [ADR_W:0] byte_adr;
    byte_adr = {adr, 1'b0};
    if (!io && byte_adr < 20'h00400) return 0;
    if (io && byte_adr == 20'h0F100) return 1;
    if (io && byte_adr == 20'h0F102) return 2;
    return 3;
  endfunction

  function automatic logic [15:0] ref_read(input logic io, input logic [ADR_W-1:0] adr);
    case (region(io, adr))
      0:       return ram_model[adr[RAM_AW-1:0]];
      1:       return 16'(sw_i);
      2:       return 16'(led_model);
      default: return 16'hFFFF;
    endcase
  endfunction

  // Vector of the lowest pending line
  function automatic logic [15:0] ref_vector(input logic [IRQ_N-1:0] pend);
    for (int i = 0; i < IRQ_N; i++) begin
      if (pend[i]) return 16'h0008 | 16'(i);
    end
    return 16'h0008;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  // One bus cycle, entered and left on a falling edge
  task automatic bus_cycle(input logic we, input logic io, input logic inta,
                           input logic [ADR_W-1:0] adr, input logic [1:0] sel,
                           input logic [15:0] wdata);
    int n;
    bus_i = '{stb: 1'b1, we: we, io: io, inta: inta, adr: adr, sel: sel, wdata: wdata};
    n = 0;
    @(negedge clk);
    while (bus_o.ack !== 1'b1 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (bus_o.ack !== 1'b1) begin
      abort_run($sformatf("Timeout: no ack for the cycle at address %h", adr));
    end else begin
      @(negedge clk);                 // Hold the request through the ack edge
      bus_i = '0;
    end
  endtask

  task automatic write_word(input logic io, input logic [ADR_W-1:0] adr, input logic [1:0] sel,
                            input logic [15:0] data);
    bus_cycle(1'b1, io, 1'b0, adr, sel, data);
    case (region(io, adr))
      0:       ram_model[adr[RAM_AW-1:0]] = merge_bytes(ram_model[adr[RAM_AW-1:0]], data, sel);
      1:       led_model = LED_W'(merge_bytes(16'(led_model), data, sel));
      default: ;
    endcase
  endtask

  task automatic read_word(input logic io, input logic [ADR_W-1:0] adr);
    chk0.expect_read(ref_read(io, adr));
    bus_cycle(1'b0, io, 1'b0, adr, 2'b11, 16'h0000);
  endtask

  task automatic ack_cycle();
    chk0.expect_read(ref_vector(pend_model));
    bus_cycle(1'b0, 1'b0, 1'b1, '0, 2'b11, 16'h0000);
    pend_model = pend_model & (pend_model - IRQ_N'(1));   // Lowest line served
  endtask

  task automatic wait_intr(input logic level);
    int n;
    n = 0;
    while (intr_o !== level && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (intr_o !== level) abort_run($sformatf("Timeout: intr_o never went to %0b", level));
  endtask

  initial begin
    seed = $urandom(34622);
    rst_lck = 1'b0;
    bus_i = '0;
    irq_i = '0;
    sw_i = '0;
    led_model = '0;
    pend_model = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_lck = 1'b1;
    @(negedge clk);

    chk0.check_ack_low();
    chk0.check_led('0);
    chk0.check_intr(1'b0);
    chk0.end_test("reset");

    // Window edges plus random words, full writes first
    test_adr.push_back(19'h00000);
    test_adr.push_back(19'h001FF);
    for (int i = 0; i < 14; i++) test_adr.push_back(ADR_W'($urandom_range(RAM_WORDS - 1)));
    for (int i = 0; i < test_adr.size(); i++) write_word(1'b0, test_adr[i], 2'b11, 16'($urandom));
    for (int i = 0; i < 24; i++) begin
      write_word(1'b0, test_adr[$urandom_range(15)], 2'($urandom), 16'($urandom));
    end
    for (int i = 0; i < test_adr.size(); i++) read_word(1'b0, test_adr[i]);
    chk0.end_test("ram");

    sw_i = SW_W'($urandom);
    write_word(1'b1, GPIO_BASE, 2'b01, 16'($urandom));
    chk0.check_led(led_model);
    write_word(1'b1, GPIO_BASE, 2'b10, 16'($urandom));
    chk0.check_led(led_model);
    read_word(1'b1, GPIO_BASE);
    read_word(1'b1, GPIO_BASE | 19'h00001);
    chk0.end_test("gpio");

    read_word(1'b0, 19'h00200);
    read_word(1'b0, 19'h7FFFF);
    read_word(1'b0, ADR_W'($urandom_range(19'h7FFFF, 19'h00200)));
    read_word(1'b1, GPIO_BASE + 19'h00002);
    read_word(1'b1, GPIO_BASE - 19'h00001);
    read_word(1'b1, 19'h00010);                            // RAM address as I/O
    write_word(1'b0, 19'h00200, 2'b11, 16'h5AA5);          // Would alias word 0
    write_word(1'b1, 19'h00000, 2'b11, 16'hA55A);
    write_word(1'b1, GPIO_BASE + 19'h00002, 2'b11, 16'h03FF);
    read_word(1'b0, 19'h00000);
    read_word(1'b1, GPIO_BASE | 19'h00001);
    chk0.check_led(led_model);
    chk0.end_test("default");

    pend_model = IRQ_N'($urandom_range(255, 1));
    irq_i = pend_model;
    wait_intr(1'b1);
    while (pend_model != '0) ack_cycle();
    wait_intr(1'b0);
    repeat (6) @(negedge clk);       // Lines stay high, no new edge
    chk0.check_intr(1'b0);
    irq_i = '0;
    chk0.end_test("irq");

    chk0.print_summary();
    if (chk0.err_total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
soc_pkg.sv
bus_decoder.sv
base_ram.sv
gpio_port.sv
irq_ctrl.sv
soc_top.sv
soc_checker.sv
tb_soc.sv

//--- Makefile
SIM      ?= verilator
SIMFLAGS ?= --binary --timing --timescale 1ns/1ps -j 0
TOP      ?= tb_soc
FILELIST ?= filelist.f
OBJDIR   ?= obj_dir
LOG      ?= sim.log

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@! grep -q "Simulation finished: FAIL" $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
